// ==== rp_analog_pkg.sv ====
/*
 * Analog path shared definitions
 * Sample widths, averaging window default, ADC word decode and the
 * negative-slope code conversion used on both converter sides
 */
`default_nettype none

package rp_analog_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADC_W        = 16;  // Raw ADC bus
  localparam int unsigned SMP_W        = 14;  // Sample and converter code
  localparam int unsigned AVG_LOG2_DEF = 6;   // 64-tap window on channel A

  typedef logic signed [SMP_W-1:0] smp_t;     // Two's complement sample
  typedef logic        [SMP_W-1:0] code_t;    // Negative-slope converter code

  // Field view of one ADC word, code sits in the upper bits
  typedef struct packed {
    logic [SMP_W-1:0]       code;  // Converter code
    logic [ADC_W-SMP_W-1:0] rsvd;  // Unused low bits of 16-bit ADC
  } adc_fld_t;

  // Same 16 bits seen raw or split into fields
  typedef union packed {
    logic [ADC_W-1:0] raw;
    adc_fld_t         fld;
  } adc_word_u;

  ////////////////////////////////////////////////////////////////////////////
  // Code conversion
  ////////////////////////////////////////////////////////////////////////////

  // Keeps the top bit, inverts the rest
  // Same rule maps code to sample and sample to code
  function automatic logic [SMP_W-1:0] neg_slope(input logic [SMP_W-1:0] x);
    return {x[SMP_W-1], ~x[SMP_W-2:0]};
  endfunction

endpackage

`default_nettype wire

// ==== adc_frontend.sv ====
/*
 * ADC front end
 * Registers both ADC words, drops the reserved bits, converts the
 * negative-slope code to two's complement and applies digital loopback
 */
`timescale 1ns/100ps
`default_nettype none

module adc_frontend (
  input  wire                                adc_clk,         // ADC clock
  input  wire                                adc_rstn,        // Sync reset, active low
  input  wire  [rp_analog_pkg::ADC_W-1:0]    adc_dat_a_i,     // Raw word channel A
  input  wire  [rp_analog_pkg::ADC_W-1:0]    adc_dat_b_i,     // Raw word channel B
  input  wire                                digital_loop_i,  // Loopback select
  input  wire  rp_analog_pkg::smp_t          loop_a_i,        // Saturated sum A
  input  wire  rp_analog_pkg::smp_t          loop_b_i,        // Saturated sum B
  output rp_analog_pkg::smp_t                adc_a_o,         // Sample channel A
  output rp_analog_pkg::smp_t                adc_b_o          // Sample channel B
);

  //////////////////////////////////////////////////////////////////////////
  // Input registers
  //////////////////////////////////////////////////////////////////////////

  rp_analog_pkg::adc_word_u adc_a_q;  // Captured word A
  rp_analog_pkg::adc_word_u adc_b_q;  // Captured word B

  rp_analog_pkg::smp_t      adc_a_cnv;
  rp_analog_pkg::smp_t      adc_b_cnv;

  // Ideally packed into IOB flops
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end else begin
      adc_a_q.raw <= adc_dat_a_i;
      adc_b_q.raw <= adc_dat_b_i;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Conversion and loopback
  //////////////////////////////////////////////////////////////////////////

  // Only the code field matters, reserved bits fall away here
  assign adc_a_cnv = rp_analog_pkg::smp_t'(rp_analog_pkg::neg_slope(adc_a_q.fld.code));
  assign adc_b_cnv = rp_analog_pkg::smp_t'(rp_analog_pkg::neg_slope(adc_b_q.fld.code));

  // Loopback path is combinational, sums show up in the same cycle
  assign adc_a_o = digital_loop_i ? loop_a_i : adc_a_cnv;
  assign adc_b_o = digital_loop_i ? loop_b_i : adc_b_cnv;

  //////////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////////

  // Loop select comes from outside, an X here corrupts both channels
  a_loop_known : assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
    !$isunknown(digital_loop_i)
  );

endmodule

`default_nettype wire

// ==== analog_mixer.sv ====
/*
 * Analog mixer
 * Adds generator and controller samples per channel and saturates
 * the 15-bit result back into 14 bits
 */
`timescale 1ns/100ps
`default_nettype none

module analog_mixer (
  input  wire  rp_analog_pkg::smp_t asg_a_i,  // Generator channel A
  input  wire  rp_analog_pkg::smp_t asg_b_i,  // Generator channel B
  input  wire  rp_analog_pkg::smp_t pid_a_i,  // Controller channel A
  input  wire  rp_analog_pkg::smp_t pid_b_i,  // Controller channel B
  output rp_analog_pkg::smp_t       sum_a_o,  // Saturated sum A
  output rp_analog_pkg::smp_t       sum_b_o   // Saturated sum B
);

  localparam int unsigned SUM_W = rp_analog_pkg::SMP_W + 1;  // One guard bit

  logic signed [SUM_W-1:0] sum_a;  // Full precision sums
  logic signed [SUM_W-1:0] sum_b;

  //////////////////////////////////////////////////////////////////////////
  // Add and saturate
  //////////////////////////////////////////////////////////////////////////

  // Limits to -8192..+8191
  // Two top bits disagree means the sum left 14-bit range
  function automatic rp_analog_pkg::smp_t sat(input logic signed [SUM_W-1:0] s);
    if (s[SUM_W-1] ^ s[SUM_W-2])
      return {s[SUM_W-1], {(SUM_W-2){~s[SUM_W-1]}}};  // Clip to rail
    else
      return s[SUM_W-2:0];
  endfunction

  // Sign extend before adding
  assign sum_a = {asg_a_i[rp_analog_pkg::SMP_W-1], asg_a_i}
               + {pid_a_i[rp_analog_pkg::SMP_W-1], pid_a_i};
  assign sum_b = {asg_b_i[rp_analog_pkg::SMP_W-1], asg_b_i}
               + {pid_b_i[rp_analog_pkg::SMP_W-1], pid_b_i};

  assign sum_a_o = sat(sum_a);
  assign sum_b_o = sat(sum_b);

  //////////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////////

  // In range sums must pass through untouched
  always_comb begin
    if (sum_a[SUM_W-1] == sum_a[SUM_W-2]) begin
      a_pass_a : assert (sum_a_o == sum_a[SUM_W-2:0]);
    end
    if (sum_b[SUM_W-1] == sum_b[SUM_W-2]) begin
      a_pass_b : assert (sum_b_o == sum_b[SUM_W-2:0]);
    end
  end

endmodule

`default_nettype wire

// ==== dac_moving_avg.sv ====
/*
 * DAC moving average
 * Running-sum averager over the last 2^AVG_LOG2 converter codes,
 * output is the upper bits of the sum, two cycles behind the input
 */
`timescale 1ns/100ps
`default_nettype none

module dac_moving_avg #(
  parameter int unsigned AVG_LOG2 = rp_analog_pkg::AVG_LOG2_DEF  // log2 of window
) (
  input  wire                         adc_clk,   // ADC clock
  input  wire                         adc_rstn,  // Sync reset, active low
  input  wire  rp_analog_pkg::code_t  code_i,    // New code every clock
  output rp_analog_pkg::code_t        avg_o      // Window average
);

  localparam int unsigned DEPTH = 2**AVG_LOG2;                      // Taps
  localparam int unsigned SUM_W = rp_analog_pkg::SMP_W + AVG_LOG2;  // No overflow

  //////////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////////

  rp_analog_pkg::code_t hist [DEPTH];  // Circular code history
  logic [AVG_LOG2-1:0]  wr_idx;        // Oldest slot, overwritten next
  logic [SUM_W-1:0]     run_sum;       // Sum of all slots in hist

  //////////////////////////////////////////////////////////////////////////
  // Running sum
  //////////////////////////////////////////////////////////////////////////

  // History starts at all zeros
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      for (int i = 0; i < DEPTH; i++) begin
        hist[i] <= '0;
      end
      wr_idx  <= '0;
      run_sum <= '0;
      avg_o   <= '0;
    end else begin
      // Add newest, drop the one it replaces
      run_sum      <= run_sum + SUM_W'(code_i) - SUM_W'(hist[wr_idx]);
      hist[wr_idx] <= code_i;
      wr_idx       <= wr_idx + 1'b1;  // Wraps at window end
      // Divide by window size, sum from previous edge
      avg_o        <= run_sum[SUM_W-1 -: rp_analog_pkg::SMP_W];
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////////

  // Index never reaches past the last tap
  a_idx_window : assert property (
    @(posedge adc_clk) disable iff (!adc_rstn)
    int'(wr_idx) < DEPTH
  );

endmodule

`default_nettype wire

// ==== dac_backend.sv ====
/*
 * DAC back end
 * Converts both saturated sums to negative-slope codes, registers
 * channel B directly and smooths channel A through the averager
 */
`timescale 1ns/100ps
`default_nettype none

module dac_backend #(
  parameter int unsigned AVG_LOG2 = rp_analog_pkg::AVG_LOG2_DEF  // Window of channel A
) (
  input  wire                         adc_clk,      // ADC clock
  input  wire                         adc_rstn,     // Sync reset, active low
  input  wire  rp_analog_pkg::smp_t   sum_a_i,      // Saturated sum A
  input  wire  rp_analog_pkg::smp_t   sum_b_i,      // Saturated sum B
  output rp_analog_pkg::code_t        dac_dat_a_o,  // Averaged code A
  output rp_analog_pkg::code_t        dac_dat_b_o   // Code B
);

  rp_analog_pkg::code_t code_a;  // Unregistered codes
  rp_analog_pkg::code_t code_b;

  //////////////////////////////////////////////////////////////////////////
  // Sample to code
  //////////////////////////////////////////////////////////////////////////

  assign code_a = rp_analog_pkg::neg_slope(sum_a_i);
  assign code_b = rp_analog_pkg::neg_slope(sum_b_i);

  //////////////////////////////////////////////////////////////////////////
  // Channel B output register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_dat_b_o <= '0;  // DAC idles at zero code
    end else begin
      dac_dat_b_o <= code_b;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Channel A smoothing
  //////////////////////////////////////////////////////////////////////////

  // Two clocks from code to output, register included
  dac_moving_avg #(
    .AVG_LOG2 (AVG_LOG2)
  ) i_avg_a (
    .adc_clk  (adc_clk    ),
    .adc_rstn (adc_rstn   ),
    .code_i   (code_a     ),
    .avg_o    (dac_dat_a_o)
  );

endmodule

`default_nettype wire

// ==== rp_analog_top.sv ====
/*
 * Analog data path top
 * ADC capture with loopback, generator plus controller mixing and
 * DAC code output with channel A smoothing, all on adc_clk
 */
`timescale 1ns/100ps
`default_nettype none

module rp_analog_top #(
  parameter int unsigned AVG_LOG2 = rp_analog_pkg::AVG_LOG2_DEF  // Channel A window
) (
  // Clock and reset
  input  wire                              adc_clk,
  input  wire                              adc_rstn,        // Sync, active low
  // ADC
  input  wire  [rp_analog_pkg::ADC_W-1:0]  adc_dat_a_i,     // Raw ADC word A
  input  wire  [rp_analog_pkg::ADC_W-1:0]  adc_dat_b_i,     // Raw ADC word B
  // Configuration
  input  wire                              digital_loop_i,  // DAC to ADC loopback
  // Generator and controller samples
  input  wire  rp_analog_pkg::smp_t        asg_a_i,
  input  wire  rp_analog_pkg::smp_t        asg_b_i,
  input  wire  rp_analog_pkg::smp_t        pid_a_i,
  input  wire  rp_analog_pkg::smp_t        pid_b_i,
  // ADC samples out, two's complement
  output rp_analog_pkg::smp_t              adc_a_o,
  output rp_analog_pkg::smp_t              adc_b_o,
  // DAC codes, negative slope
  output rp_analog_pkg::code_t             dac_dat_a_o,
  output rp_analog_pkg::code_t             dac_dat_b_o
);

  rp_analog_pkg::smp_t sum_a;  // Saturated sums, to DAC and loopback
  rp_analog_pkg::smp_t sum_b;

  ////////////////////////////////////////////////////////////////////////////
  // ADC side
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk       ),
    .adc_rstn       (adc_rstn      ),
    .adc_dat_a_i    (adc_dat_a_i   ),
    .adc_dat_b_i    (adc_dat_b_i   ),
    .digital_loop_i (digital_loop_i),
    .loop_a_i       (sum_a         ),  // Loopback taps the mixer
    .loop_b_i       (sum_b         ),
    .adc_a_o        (adc_a_o       ),
    .adc_b_o        (adc_b_o       )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Mixing
  ////////////////////////////////////////////////////////////////////////////

  analog_mixer i_mix (
    .asg_a_i (asg_a_i),
    .asg_b_i (asg_b_i),
    .pid_a_i (pid_a_i),
    .pid_b_i (pid_b_i),
    .sum_a_o (sum_a  ),
    .sum_b_o (sum_b  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // DAC side
  ////////////////////////////////////////////////////////////////////////////

  // Channels leave on separate ports, no interleaving
  dac_backend #(
    .AVG_LOG2 (AVG_LOG2)
  ) i_dac (
    .adc_clk     (adc_clk    ),
    .adc_rstn    (adc_rstn   ),
    .sum_a_i     (sum_a      ),
    .sum_b_i     (sum_b      ),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

// ==== tb_rp_analog.sv ====
/*
 * Testbench for the analog data path top
 * File vectors, a held channel A code and a random phase, all
 * checked against a reference model of the conversion rules
 */
`timescale 1ns/100ps
`default_nettype none

module tb_rp_analog;

  localparam int N_VEC  = 27;            // Lines in the stimulus file
  localparam int FIELDS = 10;            // Words per line
  localparam int N_HOLD = 70;            // Constant channel A cycles
  localparam int N_RNDM = 200;           // Random cycles
  localparam int N_RAND = N_HOLD + N_RNDM;
  localparam int T_CLK  = 40;            // ns
  localparam logic [13:0] HOLD_SMP = 14'h0555;  // Held channel A sample

  logic        adc_clk;
  logic        adc_rstn;
  logic [15:0] adc_dat_a_i;
  logic [15:0] adc_dat_b_i;
  logic        digital_loop_i;
  logic [13:0] asg_a_i;
  logic [13:0] asg_b_i;
  logic [13:0] pid_a_i;
  logic [13:0] pid_b_i;
  logic [13:0] adc_a_o;
  logic [13:0] adc_b_o;
  logic [13:0] dac_dat_a_o;
  logic [13:0] dac_dat_b_o;

  logic [15:0] vec_mem [N_VEC*FIELDS];  // Flat copy of the file
  logic [13:0] avg_hist [64];           // Model history of channel A codes
  logic [5:0]  avg_idx;                 // Model write slot
  logic [19:0] avg_sum;                 // Model running sum

  ////////////////////////////////////////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////////////////////////////////////////

  rp_analog_top #(
    .AVG_LOG2 (6)
  ) UUT (
    .adc_clk        (adc_clk       ),
    .adc_rstn       (adc_rstn      ),
    .adc_dat_a_i    (adc_dat_a_i   ),
    .adc_dat_b_i    (adc_dat_b_i   ),
    .digital_loop_i (digital_loop_i),
    .asg_a_i        (asg_a_i       ),
    .asg_b_i        (asg_b_i       ),
    .pid_a_i        (pid_a_i       ),
    .pid_b_i        (pid_b_i       ),
    .adc_a_o        (adc_a_o       ),
    .adc_b_o        (adc_b_o       ),
    .dac_dat_a_o    (dac_dat_a_o   ),
    .dac_dat_b_o    (dac_dat_b_o   )
  );

  always #(T_CLK/2) adc_clk = ~adc_clk;  // 40 ns period

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  // Top bit kept, lower 13 inverted, works both ways
  function automatic logic [13:0] conv_code(input logic [13:0] x);
    return {x[13], ~x[12:0]};
  endfunction

  // Signed add clipped to -8192..+8191
  function automatic logic [13:0] sat_sum(input logic [13:0] a, input logic [13:0] b);
    logic signed [14:0] s;
    s = $signed({a[13], a}) + $signed({b[13], b});
    if (s > 15'sd8191)
      return 14'h1FFF;
    else if (s < -15'sd8192)
      return 14'h2000;
    else
      return s[13:0];
  endfunction

  // One compare for every output
  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  // Drive one cycle, check at the next edge, advance the channel A model
  task automatic apply_cycle(input logic lp, input logic [15:0] wa, input logic [15:0] wb,
                             input logic [13:0] ga, input logic [13:0] gb,
                             input logic [13:0] pa, input logic [13:0] pb,
                             input logic [13:0] ea, input logic [13:0] eb,
                             input logic [13:0] edb);
    logic [13:0] code_a;
    logic [13:0] exp_avg;
    digital_loop_i = lp;
    adc_dat_a_i    = wa;
    adc_dat_b_i    = wb;
    asg_a_i        = ga;
    asg_b_i        = gb;
    pid_a_i        = pa;
    pid_b_i        = pb;
    @(posedge adc_clk);
    #1;
    exp_avg = avg_sum[19:6];  // Sum from before this edge
    check_value("adc_a_o", {2'b00, adc_a_o}, {2'b00, ea});
    check_value("adc_b_o", {2'b00, adc_b_o}, {2'b00, eb});
    check_value("dac_dat_b_o", {2'b00, dac_dat_b_o}, {2'b00, edb});
    check_value("dac_dat_a_o", {2'b00, dac_dat_a_o}, {2'b00, exp_avg});
    // Accept this cycle's code into the window
    code_a            = conv_code(sat_sum(ga, pa));
    avg_sum           = avg_sum + {6'd0, code_a} - {6'd0, avg_hist[avg_idx]};
    avg_hist[avg_idx] = code_a;
    avg_idx           = avg_idx + 6'd1;
    #1;  // Next drive lands 2 ns after the edge
  endtask

  // Random cycle with expected values from the rules
  task automatic random_cycle();
    logic        lp;
    logic [15:0] wa;
    logic [15:0] wb;
    logic [13:0] ga;
    logic [13:0] gb;
    logic [13:0] pa;
    logic [13:0] pb;
    logic [13:0] sa;
    logic [13:0] sb;
    lp = 1'($urandom);
    wa = 16'($urandom);
    wb = 16'($urandom);
    ga = 14'($urandom);
    gb = 14'($urandom);
    pa = 14'($urandom);
    pb = 14'($urandom);
    sa = sat_sum(ga, pa);
    sb = sat_sum(gb, pb);
    apply_cycle(lp, wa, wb, ga, gb, pa, pb,
                lp ? sa : conv_code(wa[15:2]),
                lp ? sb : conv_code(wb[15:2]),
                conv_code(sb));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int b;
    void'($urandom(32'h6b74));  // Seed once
    adc_clk        = 1'b0;
    adc_rstn       = 1'b0;
    adc_dat_a_i    = '0;
    adc_dat_b_i    = '0;
    digital_loop_i = 1'b0;
    asg_a_i        = '0;
    asg_b_i        = '0;
    pid_a_i        = '0;
    pid_b_i        = '0;
    avg_idx        = '0;
    avg_sum        = '0;
    for (int i = 0; i < 64; i++) begin
      avg_hist[i] = '0;
    end
    $readmemh("rp_analog_stimulus.txt", vec_mem);
    if ($isunknown(vec_mem[N_VEC*FIELDS-1])) begin
      $display("Stimulus file is missing or shorter than expected");
      $display("Simulation finished: FAIL");
      $fatal(1);
    end

    // Reset, DAC outputs must stay at zero
    repeat (5) begin
      @(posedge adc_clk);
      #1;
      check_value("dac_dat_a_o", {2'b00, dac_dat_a_o}, 16'h0000);
      check_value("dac_dat_b_o", {2'b00, dac_dat_b_o}, 16'h0000);
    end
    #1;
    adc_rstn = 1'b1;

    // File vectors
    for (int v = 0; v < N_VEC; v++) begin
      b = v * FIELDS;
      apply_cycle(vec_mem[b][0], vec_mem[b+1], vec_mem[b+2],
                  vec_mem[b+3][13:0], vec_mem[b+4][13:0],
                  vec_mem[b+5][13:0], vec_mem[b+6][13:0],
                  vec_mem[b+7][13:0], vec_mem[b+8][13:0], vec_mem[b+9][13:0]);
    end

    // Held channel A code, average settles on it
    repeat (N_HOLD) begin
      apply_cycle(1'b0, 16'h0000, 16'h0000, HOLD_SMP, 14'h0000, 14'h0000, 14'h0000,
                  14'h1FFF, 14'h1FFF, 14'h1FFF);
    end
    check_value("dac_dat_a_o", {2'b00, dac_dat_a_o}, {2'b00, conv_code(HOLD_SMP)});

    // Random phase
    repeat (N_RNDM) begin
      random_cycle();
    end

    $display("Simulation finished: PASS");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #((N_VEC + N_RAND + 100) * T_CLK);
    $display("Watchdog expired, the run hung before all cycles were checked");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

endmodule

`default_nettype wire

// ==== rp_analog_stimulus.txt ====
// loop adc_a adc_b asg_a asg_b pid_a pid_b | exp_adc_a exp_adc_b exp_dac_b
// All hex, samples 14-bit two's complement, one line per clock
// Loopback off, ADC conversion and channel B sums with overflow
0 0000 0000 0000 0000 0000 0000 1FFF 1FFF 1FFF
0 0003 0003 0000 1000 0000 0FFF 1FFF 1FFF 0000
0 FFFC FFFF 0000 1000 0000 1000 2000 2000 0000
0 8000 7FFC 0100 1FFF 0023 1FFF 3FFF 0000 0000
0 7FFF 8003 0100 2000 0023 2000 0000 3FFF 3FFF
0 4000 C000 0000 3000 0000 2FFF 0FFF 2FFF 3FFF
0 C002 4001 0000 3000 0000 3000 2FFF 0FFF 3FFF
0 1234 ABCD 0000 0001 0000 3FFF 1B72 350C 1FFF
0 5678 9ABC 0000 0100 0000 0023 0A61 3950 1EDC
0 ABCD 1234 0000 3F00 0000 0050 350C 1B72 20AF
0 9ABC 5678 0000 0ABC 0000 0123 3950 0A61 1420
0 0000 FFFF 0000 1FFF 0000 3FFF 1FFF 2000 0001
0 FFFF 0000 0000 2000 0000 0001 2000 1FFF 3FFE
0 1234 5678 0000 1F00 0000 0200 1B72 0A61 0000
0 ABCD 9ABC 0000 2100 0000 3E00 350C 3950 3FFF
// Loopback on, ADC outputs follow the sums in the same cycle
1 1234 5678 1000 0100 0FFF 0023 1FFF 0123 1EDC
1 0000 0000 1000 3F00 1000 0050 1FFF 3F50 20AF
1 FFFF FFFF 2000 0ABC 2000 0123 2000 0BDF 1420
1 ABCD ABCD 3000 1FFF 2FFF 3FFF 2000 1FFE 0001
1 8000 8000 0001 2000 3FFF 0001 0000 2001 3FFE
1 4000 4000 3F00 1F00 0050 0200 3F50 1FFF 0000
1 C000 C000 0ABC 2100 0123 3E00 0BDF 2000 3FFF
1 1234 1234 1FFF 0000 3FFF 0000 1FFE 0000 1FFF
1 0000 0000 2000 1000 0001 0FFF 2001 1FFF 0000
1 5678 5678 3000 3000 3000 3000 2000 2000 3FFF
// Back to ADC samples
0 7FFC 8000 1F00 0100 0200 0023 0000 3FFF 1EDC
0 0003 FFFC 0000 0000 0000 0000 1FFF 2000 1FFF

// ==== sim.f ====
rp_analog_pkg.sv
adc_frontend.sv
analog_mixer.sv
dac_moving_avg.sv
dac_backend.sv
rp_analog_top.sv
tb_rp_analog.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the analog path testbench with Verilator
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_rp_analog \
  > sim.log 2>&1 && ./obj_dir/Vtb_rp_analog >> sim.log 2>&1
grep -q "Simulation finished: FAIL" sim.log && { echo "Test failed, see sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "No result, see sim.log"; exit 1; }
echo "Test passed"
